//--- logic/opc_defs.svh
`ifndef OPC_DEFS_SVH
`define OPC_DEFS_SVH

// ------------------------------------------------------------
// operand cache sizing
// ------------------------------------------------------------

// width of operand and result data
`define OPC_DATA_W 32

// slot address bits within one unit's store
`define OPC_SLOT_W 4

// unit index bits, four units on the interconnect
`define OPC_EU_W 2

// number of slots held by the operand store
`define OPC_SLOTS (1 << `OPC_SLOT_W)

// credits per interconnect direction, also the fifo depth
`define OPC_CREDITS 4

`endif

//--- logic/opc_ctrl_pkg.sv
package opc_ctrl_pkg;

  // ------------------------------------------------------------
  // operand decode
  // ------------------------------------------------------------

  // immediate value or a reference into some unit's store
  typedef enum logic {
    OPK_IMM  = 1'b0,
    OPK_SLOT = 1'b1
  } operand_kind_e;

  // ------------------------------------------------------------
  // write port arbitration
  // ------------------------------------------------------------

  // last peer that held the store write port
  typedef enum logic {
    OWN_LOCAL = 1'b0,
    OWN_ICON  = 1'b1
  } arb_owner_e;

endpackage

//--- logic/opc_types_pkg.sv
`include "opc_defs.svh"

package opc_types_pkg;
  import opc_ctrl_pkg::*;

  // basic words
  typedef logic [`OPC_DATA_W-1:0] data_t;
  typedef logic [`OPC_SLOT_W-1:0] slot_t;

  // global operand address, unit index above the slot
  typedef struct packed {
    logic [`OPC_EU_W-1:0] eu;
    slot_t                slot;
  } eu_addr_t;

  // instruction operand
  // value holds the immediate, or an eu_addr_t in its low bits
  typedef struct packed {
    operand_kind_e kind;
    data_t         value;
  } operand_t;

  // result leaving the arithmetic pipeline
  typedef struct packed {
    eu_addr_t dst;
    data_t    data;
  } result_t;

  // one beat on either interconnect channel
  typedef struct packed {
    eu_addr_t dst;
    data_t    data;
  } icon_beat_t;

endpackage

//--- logic/store_wr_if.sv
`timescale 1ns/1ps

interface store_wr_if import opc_types_pkg::*; ();

  // request held by the requester until gnt is seen
  logic  req;
  slot_t slot;
  data_t data;

  // write takes place at the edge where req and gnt are both high
  logic  gnt;

  modport requester (
    output req,
    output slot,
    output data,
    input  gnt
  );

  modport arbiter (
    input  req,
    input  slot,
    input  data,
    output gnt
  );

endinterface

//--- logic/operand_store.sv
`timescale 1ns/1ps
`include "opc_defs.svh"

module operand_store import opc_types_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,

  // single write port, driven by the arbiter
  input  logic  wr_en_i,
  input  slot_t wr_slot_i,
  input  data_t wr_data_i,

  // two consuming read ports
  input  logic  rd0_en_i,
  input  slot_t rd0_slot_i,
  input  logic  rd1_en_i,
  input  slot_t rd1_slot_i,
  output logic  rd0_valid_o,
  output data_t rd0_data_o,
  output logic  rd1_valid_o,
  output data_t rd1_data_o
);

  data_t                 mem [`OPC_SLOTS];
  logic [`OPC_SLOTS-1:0] valid_q;
  logic [`OPC_SLOTS-1:0] valid_d;

  logic fwd0;
  logic fwd1;
  logic hit0;
  logic hit1;
  logic dup1;

  // ------------------------------------------------------------
  // read hit detection
  // ------------------------------------------------------------

  // write to the slot being read this cycle
  assign fwd0 = wr_en_i && (wr_slot_i == rd0_slot_i);
  assign fwd1 = wr_en_i && (wr_slot_i == rd1_slot_i);

  // port 0 wins when both ports name the same slot
  assign dup1 = rd0_en_i && (rd0_slot_i == rd1_slot_i);

  assign hit0 = rd0_en_i && (valid_q[rd0_slot_i] || fwd0);
  assign hit1 = rd1_en_i && !dup1 && (valid_q[rd1_slot_i] || fwd1);

  // ------------------------------------------------------------
  // valid flags
  // ------------------------------------------------------------

  // write sets the flag, a read in the same cycle clears it again
  always_comb begin
    valid_d = valid_q;
    if (wr_en_i) begin
      valid_d[wr_slot_i] = 1'b1;
    end
    if (rd0_en_i) begin
      valid_d[rd0_slot_i] = 1'b0;
    end
    if (rd1_en_i) begin
      valid_d[rd1_slot_i] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_q     <= '0;
      rd0_valid_o <= 1'b0;
      rd1_valid_o <= 1'b0;
    end else begin
      valid_q     <= valid_d;
      rd0_valid_o <= hit0;
      rd1_valid_o <= hit1;
    end
  end

  // ------------------------------------------------------------
  // data array and registered read data
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_slot_i] <= wr_data_i;
    end
    // forwarded write beats the old array contents
    rd0_data_o <= fwd0 ? wr_data_i : mem[rd0_slot_i];
    rd1_data_o <= fwd1 ? wr_data_i : mem[rd1_slot_i];
  end

endmodule

//--- logic/store_arbiter.sv
`timescale 1ns/1ps
`include "opc_defs.svh"

module store_arbiter import opc_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,

  // the two write peers
  store_wr_if.arbiter            local_wr,
  store_wr_if.arbiter            icon_wr,

  // store write port
  output logic                   wr_en_o,
  output logic [`OPC_SLOT_W-1:0] wr_slot_o,
  output logic [`OPC_DATA_W-1:0] wr_data_o
);

  arb_owner_e last_q;
  logic       gnt_local;
  logic       gnt_icon;

  // ------------------------------------------------------------
  // grant decision
  // ------------------------------------------------------------

  // lone request wins at once
  // on contention the peer that did not hold the last grant goes
  assign gnt_local = local_wr.req && (!icon_wr.req || (last_q == OWN_ICON));
  assign gnt_icon  = icon_wr.req && (!local_wr.req || (last_q == OWN_LOCAL));

  assign local_wr.gnt = gnt_local;
  assign icon_wr.gnt  = gnt_icon;

  // remember who went last
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      last_q <= OWN_ICON;
    end else if (gnt_local) begin
      last_q <= OWN_LOCAL;
    end else if (gnt_icon) begin
      last_q <= OWN_ICON;
    end
  end

  // ------------------------------------------------------------
  // write port mux
  // ------------------------------------------------------------

  assign wr_en_o   = gnt_local || gnt_icon;
  assign wr_slot_o = gnt_icon ? icon_wr.slot : local_wr.slot;
  assign wr_data_o = gnt_icon ? icon_wr.data : local_wr.data;

endmodule

//--- logic/result_router.sv
`timescale 1ns/1ps
`include "opc_defs.svh"

module result_router import opc_types_pkg::*; #(
  // index of the unit this cache belongs to
  parameter logic [`OPC_EU_W-1:0] eu_idx = '0
) (
  input  logic       clk,
  input  logic       reset_n,

  // results from the arithmetic pipeline
  input  logic       res_valid_i,
  input  result_t    res_i,
  output logic       res_ready_o,

  // local writes towards the store arbiter
  store_wr_if.requester local_wr,

  // foreign results towards the outbound queue
  output logic       txq_push_o,
  output icon_beat_t txq_beat_o,
  input  logic       txq_full_i
);

  logic  is_local;
  logic  hold_free;
  logic  hold_valid_q;
  slot_t hold_slot_q;
  data_t hold_data_q;

  assign is_local = (res_i.dst.eu == eu_idx);

  // holding register frees up at the edge where it is granted
  assign hold_free = !hold_valid_q || local_wr.gnt;

  // stall only on the path this result needs
  assign res_ready_o = is_local ? hold_free : !txq_full_i;

  // ------------------------------------------------------------
  // local path, one entry holding register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hold_valid_q <= 1'b0;
    end else if (res_valid_i && is_local && hold_free) begin
      hold_valid_q <= 1'b1;
    end else if (local_wr.gnt) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_i && is_local && hold_free) begin
      hold_slot_q <= res_i.dst.slot;
      hold_data_q <= res_i.data;
    end
  end

  assign local_wr.req  = hold_valid_q;
  assign local_wr.slot = hold_slot_q;
  assign local_wr.data = hold_data_q;

  // ------------------------------------------------------------
  // foreign path, straight into the outbound fifo
  // ------------------------------------------------------------

  assign txq_push_o      = res_valid_i && !is_local && !txq_full_i;
  assign txq_beat_o.dst  = res_i.dst;
  assign txq_beat_o.data = res_i.data;

endmodule

//--- logic/icon_rx_port.sv
`timescale 1ns/1ps
`include "opc_defs.svh"

module icon_rx_port import opc_types_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,

  // inbound interconnect channel
  input  logic       rx_valid_i,
  input  icon_beat_t rx_beat_i,
  output logic       rx_credit_o,

  // write request towards the store arbiter
  store_wr_if.requester icon_wr
);

  localparam int PTR_W = $clog2(`OPC_CREDITS);

  icon_beat_t       fifo_mem [`OPC_CREDITS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             empty;
  logic             full;
  logic             push;
  logic             pop;
  logic             credit_q;

  assign empty = (count_q == '0);
  assign full  = (count_q == (PTR_W+1)'(`OPC_CREDITS));

  // sender is credit limited, full only guards against a broken peer
  assign push = rx_valid_i && !full;
  // gnt only comes back while req is up
  assign pop  = icon_wr.gnt;

  // ------------------------------------------------------------
  // fifo pointers and fill level
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`OPC_CREDITS-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`OPC_CREDITS-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= rx_beat_i;
    end
  end

  // head entry is the pending store write
  assign icon_wr.req  = !empty;
  assign icon_wr.slot = fifo_mem[rd_ptr_q].dst.slot;
  assign icon_wr.data = fifo_mem[rd_ptr_q].data;

  // ------------------------------------------------------------
  // credit return, one cycle after each store write
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop;
    end
  end

  assign rx_credit_o = credit_q;

endmodule

//--- logic/icon_tx_queue.sv
`timescale 1ns/1ps
`include "opc_defs.svh"

module icon_tx_queue import opc_types_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,

  // foreign results from the router
  input  logic       push_i,
  input  icon_beat_t beat_i,
  output logic       full_o,

  // outbound interconnect channel
  output logic       tx_valid_o,
  output icon_beat_t tx_beat_o,
  input  logic       tx_credit_i
);

  localparam int PTR_W = $clog2(`OPC_CREDITS);
  localparam int CRD_W = $clog2(`OPC_CREDITS + 1);

  icon_beat_t       fifo_mem [`OPC_CREDITS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic [CRD_W-1:0] credit_q;
  logic             push;
  logic             send;

  assign full_o = (count_q == (PTR_W+1)'(`OPC_CREDITS));
  assign push   = push_i && !full_o;

  // one beat per cycle, only while the receiver has room
  assign send = (count_q != '0) && (credit_q != '0);

  // ------------------------------------------------------------
  // fifo
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`OPC_CREDITS-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (send) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`OPC_CREDITS-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, send})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= beat_i;
    end
  end

  // ------------------------------------------------------------
  // credits and registered output beat
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      credit_q   <= CRD_W'(`OPC_CREDITS);
      tx_valid_o <= 1'b0;
    end else begin
      tx_valid_o <= send;
      // returned credit and spent credit may cancel out
      case ({tx_credit_i, send})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      tx_beat_o <= fifo_mem[rd_ptr_q];
    end
  end

endmodule

//--- logic/operand_cache_top.sv
`timescale 1ns/1ps
`include "opc_defs.svh"

module operand_cache_top import opc_types_pkg::*; import opc_ctrl_pkg::*; #(
  // index of this unit, decides local or foreign
  parameter logic [`OPC_EU_W-1:0] eu_idx = '0
) (
  input  logic       clk,
  input  logic       reset_n,

  // pipeline results
  input  logic       res_valid_i,
  input  result_t    res_i,
  output logic       res_ready_o,

  // instruction queue request and returned operands
  input  logic       ireq_valid_i,
  input  operand_t   ireq_op0_i,
  input  operand_t   ireq_op1_i,
  output logic       op0_valid_o,
  output data_t      op0_data_o,
  output logic       op1_valid_o,
  output data_t      op1_data_o,

  // inbound interconnect
  input  logic       rx_valid_i,
  input  icon_beat_t rx_beat_i,
  output logic       rx_credit_o,

  // outbound interconnect
  output logic       tx_valid_o,
  output icon_beat_t tx_beat_o,
  input  logic       tx_credit_i
);

  operand_t   ops [2];
  logic [1:0] rd_en;
  slot_t      rd_slot [2];
  logic [1:0] rd_valid;
  data_t      rd_data [2];
  logic [1:0] op_valid;
  data_t      op_data [2];

  logic       wr_en;
  slot_t      wr_slot;
  data_t      wr_data;
  logic       txq_push;
  icon_beat_t txq_beat;
  logic       txq_full;

  store_wr_if local_wr ();
  store_wr_if icon_wr ();

  assign ops[0] = ireq_op0_i;
  assign ops[1] = ireq_op1_i;

  // ------------------------------------------------------------
  // operand decode, one lane per operand
  // ------------------------------------------------------------

  for (genvar i = 0; i < 2; i++) begin : g_opd
    eu_addr_t      addr;
    operand_kind_e kind_q;
    logic          imm_valid_q;
    data_t         imm_q;

    assign addr       = eu_addr_t'(ops[i].value[$bits(eu_addr_t)-1:0]);
    assign rd_slot[i] = addr.slot;
    // only slots of this unit live in the local store
    assign rd_en[i]   = ireq_valid_i && (ops[i].kind == OPK_SLOT) && (addr.eu == eu_idx);

    always_ff @(posedge clk) begin
      if (!reset_n) begin
        kind_q      <= OPK_IMM;
        imm_valid_q <= 1'b0;
      end else begin
        kind_q      <= ops[i].kind;
        imm_valid_q <= ireq_valid_i && (ops[i].kind == OPK_IMM);
      end
    end

    always_ff @(posedge clk) begin
      imm_q <= ops[i].value;
    end

    // store output lines up with the delayed kind bit
    assign op_valid[i] = (kind_q == OPK_IMM) ? imm_valid_q : rd_valid[i];
    assign op_data[i]  = (kind_q == OPK_IMM) ? imm_q : rd_data[i];
  end

  assign op0_valid_o = op_valid[0];
  assign op0_data_o  = op_data[0];
  assign op1_valid_o = op_valid[1];
  assign op1_data_o  = op_data[1];

  // ------------------------------------------------------------
  // submodules
  // ------------------------------------------------------------

  operand_store u_store (
    .clk         (clk),
    .reset_n     (reset_n),
    .wr_en_i     (wr_en),
    .wr_slot_i   (wr_slot),
    .wr_data_i   (wr_data),
    .rd0_en_i    (rd_en[0]),
    .rd0_slot_i  (rd_slot[0]),
    .rd1_en_i    (rd_en[1]),
    .rd1_slot_i  (rd_slot[1]),
    .rd0_valid_o (rd_valid[0]),
    .rd0_data_o  (rd_data[0]),
    .rd1_valid_o (rd_valid[1]),
    .rd1_data_o  (rd_data[1])
  );

  store_arbiter u_arb (
    .clk       (clk),
    .reset_n   (reset_n),
    .local_wr  (local_wr.arbiter),
    .icon_wr   (icon_wr.arbiter),
    .wr_en_o   (wr_en),
    .wr_slot_o (wr_slot),
    .wr_data_o (wr_data)
  );

  result_router #(
    .eu_idx (eu_idx)
  ) u_router (
    .clk         (clk),
    .reset_n     (reset_n),
    .res_valid_i (res_valid_i),
    .res_i       (res_i),
    .res_ready_o (res_ready_o),
    .local_wr    (local_wr.requester),
    .txq_push_o  (txq_push),
    .txq_beat_o  (txq_beat),
    .txq_full_i  (txq_full)
  );

  icon_rx_port u_rx (
    .clk         (clk),
    .reset_n     (reset_n),
    .rx_valid_i  (rx_valid_i),
    .rx_beat_i   (rx_beat_i),
    .rx_credit_o (rx_credit_o),
    .icon_wr     (icon_wr.requester)
  );

  icon_tx_queue u_tx (
    .clk         (clk),
    .reset_n     (reset_n),
    .push_i      (txq_push),
    .beat_i      (txq_beat),
    .full_o      (txq_full),
    .tx_valid_o  (tx_valid_o),
    .tx_beat_o   (tx_beat_o),
    .tx_credit_i (tx_credit_i)
  );

endmodule

//--- tests/operand_cache_tb.sv
`timescale 1ns/1ps
`include "opc_defs.svh"

module operand_cache_tb import opc_types_pkg::*; import opc_ctrl_pkg::*; ();

  localparam logic [`OPC_EU_W-1:0] EU_IDX = 2'd1;

  typedef enum int {
    ACT_RES, ACT_BEAT, ACT_READ, ACT_CONTEND, ACT_FWD, ACT_HOLD, ACT_RELEASE, ACT_WAIT_TX
  } act_e;

  // one stimulus row
  // dst2 and data2 carry the inbound beat of a contend row
  typedef struct {
    string    name;
    act_e     act;
    eu_addr_t dst;
    data_t    data;
    eu_addr_t dst2;
    data_t    data2;
    operand_t op0;
    operand_t op1;
    logic     has_exp;
    logic     ev0;
    data_t    ed0;
    logic     ev1;
    data_t    ed1;
  } row_t;

  logic       clk;
  logic       reset_n;
  logic       res_valid_i;
  result_t    res_i;
  logic       res_ready_o;
  logic       ireq_valid_i;
  operand_t   ireq_op0_i;
  operand_t   ireq_op1_i;
  logic       op0_valid_o;
  data_t      op0_data_o;
  logic       op1_valid_o;
  data_t      op1_data_o;
  logic       rx_valid_i;
  icon_beat_t rx_beat_i;
  logic       rx_credit_o;
  logic       tx_valid_o;
  icon_beat_t tx_beat_o;
  logic       tx_credit_i = 1'b0;

  // reference model of the store and both channel peers
  logic         model_valid [`OPC_SLOTS];
  data_t        model_data [`OPC_SLOTS];
  icon_beat_t   tx_expect [$];
  int           tx_seen = 0;
  int           tx_owed = 0;
  logic         tx_release = 1'b1;
  int           rx_sent = 0;
  int           rx_pulses = 0;
  logic [31:0]  lcg_state = 32'h437a9361;
  row_t         table_q [$];
  row_t         rnd;

  operand_cache_top #(.eu_idx(EU_IDX)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // reporting
  // ------------------------------------------------------------

  function automatic void abort_run(string what);
    $display("ERROR: %s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endfunction

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ------------------------------------------------------------
  // channel peer models
  // ------------------------------------------------------------

  // outbound receiver checks order and gives credits back when allowed
  always @(posedge clk) begin
    if (reset_n === 1'b1 && tx_valid_o === 1'b1) begin
      if (tx_expect.size() == 0) begin
        abort_run("outbound beat sent while none was expected");
      end
      check_value("tx beat", 64'(tx_expect[0]), 64'(tx_beat_o));
      void'(tx_expect.pop_front());
      tx_seen = tx_seen + 1;
      tx_owed = tx_owed + 1;
      if (tx_owed > `OPC_CREDITS) begin
        abort_run("outbound queue sent more beats than it had credits");
      end
    end
    if (tx_release && tx_owed > 0) begin
      tx_credit_i <= 1'b1;
      tx_owed = tx_owed - 1;
    end else begin
      tx_credit_i <= 1'b0;
    end
  end

  // inbound sender credit returns
  // each pulse must match a beat still outstanding
  always @(posedge clk) begin
    if (reset_n === 1'b1 && rx_credit_o === 1'b1) begin
      if (rx_pulses >= rx_sent) begin
        abort_run("rx_credit_o pulsed with no inbound beat outstanding");
      end
      rx_pulses = rx_pulses + 1;
    end
  end

  // ------------------------------------------------------------
  // row helpers
  // ------------------------------------------------------------

  function automatic operand_t imm_op(data_t v);
    return {OPK_IMM, v};
  endfunction

  function automatic operand_t slot_op(logic [`OPC_EU_W-1:0] eu, slot_t s);
    return {OPK_SLOT, 26'b0, eu, s};
  endfunction

  function automatic row_t base_row(string name, act_e act);
    row_t r;
    r = '{name: name, act: act, dst: '0, data: '0, dst2: '0, data2: '0, op0: '0, op1: '0,
          has_exp: 1'b0, ev0: 1'b0, ed0: '0, ev1: 1'b0, ed1: '0};
    return r;
  endfunction

  function automatic row_t wr_row(string name, act_e act, eu_addr_t dst, data_t data);
    row_t r;
    r = base_row(name, act);
    r.dst = dst;
    r.data = data;
    return r;
  endfunction

  function automatic row_t rd_row(string name, operand_t op0, operand_t op1,
                                  logic ev0, data_t ed0, logic ev1, data_t ed1);
    row_t r;
    r = base_row(name, ACT_READ);
    r.op0 = op0;
    r.op1 = op1;
    r.has_exp = 1'b1;
    r.ev0 = ev0;
    r.ed0 = ed0;
    r.ev1 = ev1;
    r.ed1 = ed1;
    return r;
  endfunction

  // picks a slot the model shows empty and not equal to excl
  function automatic slot_t pick_empty(int excl);
    slot_t s;
    int    n;
    s = slot_t'(lcg_next() >> 8);
    n = 0;
    while (model_valid[s] || int'(s) == excl) begin
      s = s + 1'b1;
      n = n + 1;
      if (n > `OPC_SLOTS) begin
        abort_run("no empty slot left for a random write");
      end
    end
    return s;
  endfunction

  // ------------------------------------------------------------
  // bus tasks
  // ------------------------------------------------------------

  task automatic send_result(eu_addr_t dst, data_t data);
    int t = 0;
    @(posedge clk);
    res_valid_i <= 1'b1;
    res_i       <= {dst, data};
    @(negedge clk);
    while (res_ready_o !== 1'b1) begin
      t = t + 1;
      if (t > 200) abort_run("timeout waiting for res_ready_o");
      @(negedge clk);
    end
    @(posedge clk);
    res_valid_i <= 1'b0;
    if (dst.eu == EU_IDX) begin
      model_valid[dst.slot] = 1'b1;
      model_data[dst.slot]  = data;
    end else begin
      tx_expect.push_back({dst, data});
    end
  endtask

  task automatic send_beat(eu_addr_t dst, data_t data);
    int t = 0;
    @(negedge clk);
    while (`OPC_CREDITS - rx_sent + rx_pulses <= 0) begin
      t = t + 1;
      if (t > 200) abort_run("timeout waiting for an rx_credit_o pulse");
      @(negedge clk);
    end
    @(posedge clk);
    rx_valid_i <= 1'b1;
    rx_beat_i  <= {dst, data};
    rx_sent = rx_sent + 1;
    @(posedge clk);
    rx_valid_i <= 1'b0;
    model_valid[dst.slot] = 1'b1;
    model_data[dst.slot]  = data;
  endtask

  // waits until both write paths have reached the store
  task automatic wait_idle();
    int t = 0;
    @(negedge clk);
    while (!(rx_pulses == rx_sent && res_ready_o === 1'b1)) begin
      t = t + 1;
      if (t > 200) abort_run("timeout waiting for pending store writes to drain");
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // local result and inbound beat go in the same cycle so both peers request together
  task automatic contend(row_t r);
    wait_idle();
    @(posedge clk);
    res_valid_i <= 1'b1;
    res_i       <= {r.dst, r.data};
    rx_valid_i  <= 1'b1;
    rx_beat_i   <= {r.dst2, r.data2};
    rx_sent = rx_sent + 1;
    @(posedge clk);
    res_valid_i <= 1'b0;
    rx_valid_i  <= 1'b0;
    model_valid[r.dst.slot]  = 1'b1;
    model_data[r.dst.slot]   = r.data;
    model_valid[r.dst2.slot] = 1'b1;
    model_data[r.dst2.slot]  = r.data2;
  endtask

  task automatic wait_tx(string name, int count);
    int t = 0;
    @(negedge clk);
    while (tx_seen < count) begin
      t = t + 1;
      if (t > 300) abort_run("timeout waiting for tx_valid_o beats");
      @(negedge clk);
    end
    // with credits held nothing more may leave
    if (!tx_release) begin
      repeat (8) @(posedge clk);
      check_value(name, 64'(count), 64'(tx_seen));
    end
  endtask

  // model prediction where a slot read consumes the slot
  task automatic predict(operand_t op, output logic v, output data_t d);
    eu_addr_t a;
    a = eu_addr_t'(op.value[$bits(eu_addr_t)-1:0]);
    v = 1'b0;
    d = '0;
    if (op.kind == OPK_IMM) begin
      v = 1'b1;
      d = op.value;
    end else if (a.eu == EU_IDX) begin
      v = model_valid[a.slot];
      d = model_data[a.slot];
      model_valid[a.slot] = 1'b0;
    end
  endtask

  // drives one instruction at the current edge and checks its operands a cycle later
  task automatic issue_read(row_t r);
    logic  v0;
    logic  v1;
    data_t d0;
    data_t d1;
    predict(r.op0, v0, d0);
    predict(r.op1, v1, d1);
    ireq_valid_i <= 1'b1;
    ireq_op0_i   <= r.op0;
    ireq_op1_i   <= r.op1;
    @(posedge clk);
    ireq_valid_i <= 1'b0;
    @(negedge clk);
    if (r.has_exp) begin
      check_value({r.name, " table op0 valid"}, 64'(r.ev0), 64'(v0));
      check_value({r.name, " table op1 valid"}, 64'(r.ev1), 64'(v1));
    end
    check_value({r.name, " op0 valid"}, 64'(v0), 64'(op0_valid_o));
    check_value({r.name, " op1 valid"}, 64'(v1), 64'(op1_valid_o));
    if (v0) check_value({r.name, " op0 data"}, 64'(d0), 64'(op0_data_o));
    if (v1) check_value({r.name, " op1 data"}, 64'(d1), 64'(op1_data_o));
    if (r.has_exp && r.ev0) check_value({r.name, " table op0 data"}, 64'(r.ed0), 64'(d0));
    if (r.has_exp && r.ev1) check_value({r.name, " table op1 data"}, 64'(r.ed1), 64'(d1));
  endtask

  task automatic do_read(row_t r);
    wait_idle();
    @(posedge clk);
    issue_read(r);
  endtask

  // the read reaches the store in the cycle the uncontended local write lands
  task automatic forward_read(row_t r);
    wait_idle();
    send_result(r.dst, r.data);
    issue_read(r);
  endtask

  task automatic apply_row(row_t r);
    case (r.act)
      ACT_RES:     send_result(r.dst, r.data);
      ACT_BEAT:    send_beat(r.dst, r.data);
      ACT_CONTEND: contend(r);
      ACT_READ:    do_read(r);
      ACT_FWD:     forward_read(r);
      ACT_HOLD:    tx_release = 1'b0;
      ACT_RELEASE: tx_release = 1'b1;
      ACT_WAIT_TX: wait_tx(r.name, int'(r.data));
      default:     abort_run("unknown row action");
    endcase
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    reset_n      <= 1'b0;
    res_valid_i  <= 1'b0;
    res_i        <= '0;
    ireq_valid_i <= 1'b0;
    ireq_op0_i   <= '0;
    ireq_op1_i   <= '0;
    rx_valid_i   <= 1'b0;
    rx_beat_i    <= '0;
    for (int i = 0; i < `OPC_SLOTS; i++) begin
      model_valid[i] = 1'b0;
      model_data[i]  = '0;
    end

    // local write then consuming reads
    table_q.push_back(wr_row("local_wr", ACT_RES, {EU_IDX, 4'd3}, 32'h1111_2222));
    table_q.push_back(rd_row("local_rd", slot_op(EU_IDX, 4'd3), imm_op(32'd5),
                             1'b1, 32'h1111_2222, 1'b1, 32'd5));
    table_q.push_back(rd_row("local_rd_again", slot_op(EU_IDX, 4'd3), imm_op(32'd0),
                             1'b0, 32'd0, 1'b1, 32'd0));
    // immediate and foreign slot
    table_q.push_back(rd_row("imm_foreign", imm_op(32'hdead_beef), slot_op(2'd2, 4'd4),
                             1'b1, 32'hdead_beef, 1'b0, 32'd0));
    // outbound credits held then released
    table_q.push_back(base_row("tx_hold", ACT_HOLD));
    for (int i = 0; i < 6; i++) begin
      table_q.push_back(wr_row("tx_res", ACT_RES, {2'd2, 4'(i)}, 32'hab00_0000 + 32'(i)));
    end
    table_q.push_back(wr_row("tx_limit", ACT_WAIT_TX, '0, 32'(`OPC_CREDITS)));
    table_q.push_back(base_row("tx_release", ACT_RELEASE));
    table_q.push_back(wr_row("tx_rest", ACT_WAIT_TX, '0, 32'd6));
    // inbound beats
    table_q.push_back(wr_row("rx_beat", ACT_BEAT, {EU_IDX, 4'd7}, 32'h7777_0007));
    table_q.push_back(wr_row("rx_beat", ACT_BEAT, {EU_IDX, 4'd8}, 32'h8888_0008));
    table_q.push_back(wr_row("rx_beat", ACT_BEAT, {EU_IDX, 4'd9}, 32'h9999_0009));
    table_q.push_back(rd_row("rx_rd", slot_op(EU_IDX, 4'd7), slot_op(EU_IDX, 4'd8),
                             1'b1, 32'h7777_0007, 1'b1, 32'h8888_0008));
    table_q.push_back(rd_row("rx_rd_dup", slot_op(EU_IDX, 4'd9), slot_op(EU_IDX, 4'd9),
                             1'b1, 32'h9999_0009, 1'b0, 32'd0));
    // write and read of one slot in the same cycle on each read port
    rnd = rd_row("fwd_rd0", slot_op(EU_IDX, 4'd5), imm_op(32'd1),
                 1'b1, 32'h5555_0005, 1'b1, 32'd1);
    rnd.act  = ACT_FWD;
    rnd.dst  = {EU_IDX, 4'd5};
    rnd.data = 32'h5555_0005;
    table_q.push_back(rnd);
    rnd = rd_row("fwd_rd1", imm_op(32'd2), slot_op(EU_IDX, 4'd6),
                 1'b1, 32'd2, 1'b1, 32'h6666_0006);
    rnd.act  = ACT_FWD;
    rnd.dst  = {EU_IDX, 4'd6};
    rnd.data = 32'h6666_0006;
    table_q.push_back(rnd);
    table_q.push_back(rd_row("fwd_rd_again", slot_op(EU_IDX, 4'd5), slot_op(EU_IDX, 4'd6),
                             1'b0, 32'd0, 1'b0, 32'd0));

    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_value("reset res_ready", 64'd1, 64'(res_ready_o));
    check_value("reset op0_valid", 64'd0, 64'(op0_valid_o));
    check_value("reset op1_valid", 64'd0, 64'(op1_valid_o));
    check_value("reset tx_valid", 64'd0, 64'(tx_valid_o));
    check_value("reset rx_credit", 64'd0, 64'(rx_credit_o));

    foreach (table_q[i]) begin
      apply_row(table_q[i]);
    end
    wait_idle();

    // random contention rounds
    for (int i = 0; i < 16; i++) begin
      rnd = base_row("rand_contend", ACT_CONTEND);
      rnd.dst   = {EU_IDX, pick_empty(-1)};
      rnd.data  = lcg_next();
      rnd.dst2  = {EU_IDX, pick_empty(int'(rnd.dst.slot))};
      rnd.data2 = lcg_next();
      apply_row(rnd);
      apply_row(wr_row("rand_rd", ACT_READ, '0, '0));
      rnd.act = ACT_READ;
      rnd.name = "rand_rd_a";
      rnd.op0 = slot_op(EU_IDX, rnd.dst.slot);
      rnd.op1 = slot_op(EU_IDX, slot_t'(lcg_next() >> 12));
      apply_row(rnd);
      rnd.name = "rand_rd_b";
      rnd.op0 = slot_op(EU_IDX, rnd.dst2.slot);
      rnd.op1 = imm_op(lcg_next());
      apply_row(rnd);
    end

    wait_idle();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
logic/opc_ctrl_pkg.sv
logic/opc_types_pkg.sv
logic/store_wr_if.sv
logic/operand_store.sv
logic/store_arbiter.sv
logic/result_router.sv
logic/icon_rx_port.sv
logic/icon_tx_queue.sv
logic/operand_cache_top.sv
tests/operand_cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the operand cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module operand_cache_tb -o operand_cache_sim \
  && ./obj_dir/operand_cache_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
  && exit 0 \
  || { echo "simulation did not pass"; exit 1; }
